//--- Bender.yml
package:
  name: soc_domain

sources:
  - source/soc_domain_pkg.sv
  - source/soc_reset_ctrl.sv
  - source/apb_per_bridge.sv
  - source/debug_scratch_mem.sv
  - source/clk_lock_monitor.sv
  - source/soc_domain_top.sv
  - target: simulation
    files:
      - sim/tb_checker.sv
      - sim/tb_soc_domain.sv

//--- sim.f
source/soc_domain_pkg.sv
source/soc_reset_ctrl.sv
source/apb_per_bridge.sv
source/debug_scratch_mem.sv
source/clk_lock_monitor.sv
source/soc_domain_top.sv
sim/tb_checker.sv
sim/tb_soc_domain.sv

//--- sim/tb_checker.sv
// checker for the SoC domain testbench, watches the APB side of the DUT
// samples on the rising edge, a transfer completes on an edge with pready high
// the model memory follows completed writes and clears while the periph reset is low
// the testbench top sets the running test through begin_test and end_test

`timescale 1ns/1ps

module tb_checker (
  input logic                      s_soc_clk,
  input logic                      periph_rstn_i,
  input logic                      psel_i,
  input logic                      penable_i,
  input logic                      pwrite_i,
  input soc_domain_pkg::apb_addr_t paddr_i,
  input soc_domain_pkg::apb_data_t pwdata_i,
  input soc_domain_pkg::apb_data_t prdata_i,
  input logic                      pready_i,
  input logic                      pslverr_i
);

  localparam int unsigned WORDS = soc_domain_pkg::DBG_MEM_WORDS;
  localparam int unsigned IDX_W = $bits(soc_domain_pkg::dbg_mem_idx_t);

  soc_domain_pkg::apb_data_t model_q [WORDS];
  // running test and its expectation
  string                     cur_name = "idle";
  logic                      cur_xfer = 1'b0;
  soc_domain_pkg::apb_data_t cur_exp_data = '0;
  logic                      cur_exp_err = 1'b0;
  int                        test_errs = 0;
  int                        resp_cnt = 0;
  // access cycles seen so far in the open transfer
  int                        access_cnt = 0;
  int                        pass_cnt = 0;
  int                        fail_cnt = 0;
  int                        total_errs = 0;

  // ****************************************
  // test bookkeeping
  // ****************************************

  task automatic begin_test(input string name, input logic xfer,
                            input soc_domain_pkg::apb_data_t exp_data, input logic exp_err);
    cur_name     = name;
    cur_xfer     = xfer;
    cur_exp_data = exp_data;
    cur_exp_err  = exp_err;
    test_errs    = 0;
    resp_cnt     = 0;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error: %s %s expected %h actual %h", cur_name, what, exp, act);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("test %s went wrong: %s", cur_name, msg);
    test_errs++;
    total_errs++;
  endtask

  task automatic end_test();
    // a transfer answers exactly once
    if (cur_xfer && resp_cnt != 1) begin
      report_problem($sformatf("saw %0d pready pulses instead of one", resp_cnt));
    end
    if (test_errs == 0) begin
      pass_cnt++;
      $display("pass  %s", cur_name);
    end else begin
      fail_cnt++;
      $display("fail  %s (%0d problems)", cur_name, test_errs);
    end
    cur_xfer = 1'b0;
    cur_name = "idle";
  endtask

  // ****************************************
  // transfer monitor
  // ****************************************

  always @(posedge s_soc_clk) begin : sample
    soc_domain_pkg::apb_data_t    exp_model;
    soc_domain_pkg::dbg_mem_idx_t idx;
    logic                         in_range;
    in_range = (paddr_i < 4 * WORDS);
    idx      = paddr_i[2 +: IDX_W];
    if (!periph_rstn_i) begin
      for (int i = 0; i < WORDS; i++) begin
        model_q[i] = '0;
      end
      access_cnt = 0;
    end else if (psel_i && penable_i) begin
      // response comes in the second access cycle and not before
      if (access_cnt == 0 && pready_i) begin
        report_problem("pready high in the first access cycle");
      end
      if (access_cnt == 1 && !pready_i) begin
        report_problem("pready low in the second access cycle");
      end
      if (pready_i) begin
        resp_cnt++;
        exp_model = in_range ? model_q[idx] : '0;
        check_value("pslverr", cur_exp_err, pslverr_i);
        if (!pwrite_i) begin
          check_value("prdata", cur_exp_data, prdata_i);
          check_value("prdata against model", exp_model, prdata_i);
        end else if (in_range) begin
          model_q[idx] = pwdata_i;
        end
      end
      access_cnt++;
    end else begin
      if (pready_i) begin
        report_problem("pready high outside an access phase");
      end
      access_cnt = 0;
    end
  end

endmodule

//--- sim/tb_soc_domain.sv
// testbench top for soc_domain_top
// inputs change on the falling clock edge, outputs are read there too
// the stimulus table is filled at time zero, random write data is drawn then
// every comparison goes through the tb_checker instance

`timescale 1ns/1ps

module tb_soc_domain;

  localparam int unsigned CLK_PERIOD = 20;
  localparam int unsigned NUM_TESTS  = 18;
  localparam int unsigned STAGES     = soc_domain_pkg::RST_SYNC_STAGES;
  localparam int unsigned REF_BLINK  = soc_domain_pkg::REF_BLINK_CYCLES;
  localparam int unsigned ETH_BLINK  = soc_domain_pkg::ETH_BLINK_CYCLES;

  // table operations
  localparam int OP_WRITE    = 0;
  localparam int OP_READ     = 1;
  localparam int OP_WD       = 2;
  localparam int OP_NDM      = 3;
  localparam int OP_LOCK_ON  = 4;
  localparam int OP_LOCK_OFF = 5;

  logic                      s_soc_clk;
  logic                      s_soc_rstn;
  soc_domain_pkg::apb_addr_t paddr;
  soc_domain_pkg::apb_data_t pwdata;
  logic                      pwrite;
  logic                      psel;
  logic                      penable;
  soc_domain_pkg::apb_data_t prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      wd_expired;
  logic                      ndmreset;
  logic                      ref_lock;
  logic                      eth_lock;
  logic                      periph_rstn;
  logic                      ld_ref_lock;
  logic                      ld_ref_blink;
  logic                      ld_eth_lock;
  logic                      ld_eth_blink;

  // ****************************************
  // stimulus table
  // ****************************************

  string                     tbl_name [NUM_TESTS];
  int                        tbl_op   [NUM_TESTS];
  soc_domain_pkg::apb_addr_t tbl_addr [NUM_TESTS];
  soc_domain_pkg::apb_data_t tbl_data [NUM_TESTS];
  soc_domain_pkg::apb_data_t tbl_exp  [NUM_TESTS];
  logic                      tbl_err  [NUM_TESTS];
  // idle cycles after a transfer, pulse length or observed lock cycles
  int                        tbl_wait [NUM_TESTS];
  int                        n_fill;
  int                        seed;

  soc_domain_top u_dut (
    .s_soc_clk          (s_soc_clk),
    .s_soc_rstn         (s_soc_rstn),
    .paddr_i            (paddr),
    .pwdata_i           (pwdata),
    .pwrite_i           (pwrite),
    .psel_i             (psel),
    .penable_i          (penable),
    .prdata_o           (prdata),
    .pready_o           (pready),
    .pslverr_o          (pslverr),
    .wd_expired_i       (wd_expired),
    .ndmreset_i         (ndmreset),
    .ref_lock_i         (ref_lock),
    .eth_lock_i         (eth_lock),
    .periph_rstn_o      (periph_rstn),
    .ld_ref_clk_lock_o  (ld_ref_lock),
    .ld_ref_clk_blink_o (ld_ref_blink),
    .ld_eth_clk_lock_o  (ld_eth_lock),
    .ld_eth_clk_blink_o (ld_eth_blink)
  );

  tb_checker u_chk (
    .s_soc_clk     (s_soc_clk),
    .periph_rstn_i (periph_rstn),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .paddr_i       (paddr),
    .pwdata_i      (pwdata),
    .prdata_i      (prdata),
    .pready_i      (pready),
    .pslverr_i     (pslverr)
  );

  initial s_soc_clk = 1'b0;
  always #(CLK_PERIOD / 2) s_soc_clk = ~s_soc_clk;

  task automatic add_entry(input string name, input int op, input soc_domain_pkg::apb_addr_t addr,
                           input soc_domain_pkg::apb_data_t data,
                           input soc_domain_pkg::apb_data_t exp, input logic err,
                           input int wait_cyc);
    tbl_name[n_fill] = name;
    tbl_op[n_fill]   = op;
    tbl_addr[n_fill] = addr;
    tbl_data[n_fill] = data;
    tbl_exp[n_fill]  = exp;
    tbl_err[n_fill]  = err;
    tbl_wait[n_fill] = wait_cyc;
    n_fill++;
  endtask

  task automatic build_table();
    soc_domain_pkg::apb_data_t r0;
    soc_domain_pkg::apb_data_t r3;
    soc_domain_pkg::apb_data_t r3b;
    soc_domain_pkg::apb_data_t r15;
    soc_domain_pkg::apb_data_t r2;
    r0  = $random(seed);
    r3  = $random(seed);
    r3b = $random(seed);
    r15 = $random(seed);
    r2  = $random(seed);
    add_entry("write word 0", OP_WRITE, 32'h00, r0, '0, 1'b0, 1);
    add_entry("write word 3", OP_WRITE, 32'h0c, r3, '0, 1'b0, 1);
    add_entry("write word 15", OP_WRITE, 32'h3c, r15, '0, 1'b0, 1);
    // low address bits ignored, lands on word 3 again
    add_entry("rewrite word 3 unaligned", OP_WRITE, 32'h0e, r3b, '0, 1'b0, 1);
    add_entry("read word 0", OP_READ, 32'h00, '0, r0, 1'b0, 1);
    add_entry("read word 3", OP_READ, 32'h0c, '0, r3b, 1'b0, 1);
    add_entry("read word 15", OP_READ, 32'h3c, '0, r15, 1'b0, 1);
    add_entry("read unwritten word 8", OP_READ, 32'h20, '0, '0, 1'b0, 1);
    add_entry("write out of range", OP_WRITE, 32'h40, r2, '0, 1'b1, 1);
    add_entry("read out of range", OP_READ, 32'h100, '0, '0, 1'b1, 1);
    // both out of range addresses alias word 0 in bits 5 to 2
    add_entry("read word 0 after error", OP_READ, 32'h00, '0, r0, 1'b0, 1);
    add_entry("watchdog reset pulse", OP_WD, '0, '0, '0, 1'b0, 3);
    add_entry("read word 0 after watchdog", OP_READ, 32'h00, '0, '0, 1'b0, 1);
    add_entry("write word 2", OP_WRITE, 32'h08, r2, '0, 1'b0, 1);
    add_entry("ndmreset pulse", OP_NDM, '0, '0, '0, 1'b0, 2);
    add_entry("read word 2 after ndmreset", OP_READ, 32'h08, '0, '0, 1'b0, 1);
    add_entry("clock locks on", OP_LOCK_ON, '0, '0, '0, 1'b0, 30);
    add_entry("clock locks off", OP_LOCK_OFF, '0, '0, '0, 1'b0, 4);
  endtask

  // ****************************************
  // operations
  // ****************************************

  // setup cycle, then access until pready
  task automatic apb_transfer(input int i);
    int cyc;
    cyc     = 0;
    paddr   = tbl_addr[i];
    pwdata  = tbl_data[i];
    pwrite  = (tbl_op[i] == OP_WRITE);
    psel    = 1'b1;
    @(negedge s_soc_clk);
    penable = 1'b1;
    @(negedge s_soc_clk);
    while (!pready && cyc < 8) begin
      @(negedge s_soc_clk);
      cyc++;
    end
    if (!pready) begin
      u_chk.report_problem("no pready within eight access cycles");
    end
    // completing edge lies between here and the next falling edge
    @(negedge s_soc_clk);
    psel    = 1'b0;
    penable = 1'b0;
    repeat (tbl_wait[i]) @(negedge s_soc_clk);
  endtask

  task automatic reset_pulse(input int i);
    if (tbl_op[i] == OP_WD) begin
      wd_expired = 1'b1;
    end else begin
      ndmreset = 1'b1;
    end
    // assertion is asynchronous
    #1;
    u_chk.check_value("periph_rstn at assertion", 32'd0, periph_rstn);
    repeat (tbl_wait[i]) begin
      @(negedge s_soc_clk);
      u_chk.check_value("periph_rstn while source high", 32'd0, periph_rstn);
    end
    wd_expired = 1'b0;
    ndmreset   = 1'b0;
    // release on the STAGES-th rising edge
    for (int k = 1; k <= STAGES + 1; k++) begin
      @(negedge s_soc_clk);
      u_chk.check_value($sformatf("periph_rstn %0d edges after release", k),
                        (k >= STAGES), periph_rstn);
    end
  endtask

  task automatic lock_levels(input int i);
    logic lock_on;
    lock_on  = (tbl_op[i] == OP_LOCK_ON);
    ref_lock = lock_on;
    eth_lock = lock_on;
    // LEDs keep the old level until the next rising edge
    #1;
    u_chk.check_value("ref lock LED before edge", !lock_on, ld_ref_lock);
    u_chk.check_value("eth lock LED before edge", !lock_on, ld_eth_lock);
    // lock LED rose at edge 1, blink flips every BLINK edges after that
    for (int k = 1; k <= tbl_wait[i]; k++) begin
      @(negedge s_soc_clk);
      u_chk.check_value("ref lock LED", lock_on, ld_ref_lock);
      u_chk.check_value("eth lock LED", lock_on, ld_eth_lock);
      u_chk.check_value("ref blink LED", lock_on ? ((k - 1) / REF_BLINK) % 2 : 0, ld_ref_blink);
      u_chk.check_value("eth blink LED", lock_on ? ((k - 1) / ETH_BLINK) % 2 : 0, ld_eth_blink);
    end
  endtask

  // ****************************************
  // main sequence
  // ****************************************

  initial begin
    s_soc_rstn = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    pwrite     = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    wd_expired = 1'b0;
    ndmreset   = 1'b0;
    ref_lock   = 1'b0;
    eth_lock   = 1'b0;
    n_fill     = 0;
    seed       = 74757;
    build_table();
    repeat (3) @(negedge s_soc_clk);
    s_soc_rstn = 1'b1;
    // let the periph reset release before the first transfer
    repeat (STAGES + 1) @(negedge s_soc_clk);
    for (int i = 0; i < NUM_TESTS; i++) begin
      u_chk.begin_test(tbl_name[i], (tbl_op[i] <= OP_READ), tbl_exp[i], tbl_err[i]);
      case (tbl_op[i])
        OP_WRITE, OP_READ: apb_transfer(i);
        OP_WD, OP_NDM:     reset_pulse(i);
        default:           lock_levels(i);
      endcase
      u_chk.end_test();
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", NUM_TESTS, u_chk.pass_cnt,
             u_chk.fail_cnt, u_chk.total_errs);
    if (u_chk.fail_cnt == 0 && u_chk.total_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // run limit, generous for every table entry
  initial begin
    #(NUM_TESTS * 40 * CLK_PERIOD + 1000);
    $display("run timed out before all tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- source/apb_per_bridge.sv
// APB slave to per bus request bridge
// one per request per access phase, grant is tied to the request
// response valid follows the grant by one cycle and becomes pready
// every transfer is setup plus two access cycles, no extra wait states
// no byte enables, every write is a whole word

`timescale 1ns/1ps

module apb_per_bridge (
  input  logic                      s_soc_clk,
  input  logic                      s_soc_rstn,
  input  soc_domain_pkg::apb_addr_t paddr_i,
  input  soc_domain_pkg::apb_data_t pwdata_i,
  input  logic                      pwrite_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  output soc_domain_pkg::apb_data_t prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  output logic                      per_req_o,
  output soc_domain_pkg::apb_addr_t per_addr_o,
  output logic                      per_we_o,
  output soc_domain_pkg::apb_data_t per_wdata_o,
  input  soc_domain_pkg::apb_data_t per_rdata_i,
  input  logic                      per_err_i
);

  logic access;
  // grant straight from request, the memory never stalls
  logic per_gnt;
  logic r_valid_q;
  // set once this access phase got its response
  logic done_q;

  // ****************************************
  // request side
  // ****************************************

  assign access  = psel_i & penable_i;
  // no second request while the answer is pending or already given
  assign per_req_o   = access & ~r_valid_q & ~done_q;
  assign per_gnt     = per_req_o;
  assign per_addr_o  = paddr_i;
  assign per_we_o    = pwrite_i;
  assign per_wdata_o = pwdata_i;

  // ****************************************
  // response side
  // ****************************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      r_valid_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      r_valid_q <= per_gnt;
      // cleared as soon as the master leaves the access phase
      done_q    <= access & (done_q | r_valid_q);
    end
  end

  assign pready_o  = r_valid_q;
  // memory holds its data register, error only counts with pready
  assign prdata_o  = per_rdata_i;
  assign pslverr_o = r_valid_q & per_err_i;

  // pready only ever answers an open access phase
  a_ready_in_access : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    $rose(pready_o) |-> (psel_i && penable_i))
    else $error("pready raised outside an APB access phase");

endmodule

//--- source/clk_lock_monitor.sv
// lock and blink LEDs for one clock source
// locked_i must already be sampled on s_soc_clk
// lock LED follows the input one cycle later
// blink toggles every BLINK_CYCLES cycles while locked, low when unlocked

`timescale 1ns/1ps

module clk_lock_monitor #(
  parameter int unsigned BLINK_CYCLES = soc_domain_pkg::REF_BLINK_CYCLES
) (
  input  logic s_soc_clk,
  input  logic s_soc_rstn,
  input  logic locked_i,
  output logic ld_lock_o,
  output logic ld_blink_o
);

  localparam int unsigned CNT_W = (BLINK_CYCLES > 1) ? $clog2(BLINK_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLINK_CYCLES - 1);

  logic [CNT_W-1:0] cnt_q;

  // ****************************************
  // lock register and blink divider
  // ****************************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      ld_lock_o  <= 1'b0;
      ld_blink_o <= 1'b0;
      cnt_q      <= '0;
    end else begin
      ld_lock_o <= locked_i;
      // counting starts the cycle the lock LED rose
      if (!locked_i || !ld_lock_o) begin
        cnt_q      <= '0;
        ld_blink_o <= 1'b0;
      end else if (cnt_q == CNT_LAST) begin
        cnt_q      <= '0;
        ld_blink_o <= ~ld_blink_o;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // blink never runs on from an unlocked cycle
  a_blink_needs_lock : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    !ld_lock_o |=> !ld_blink_o)
    else $error("blink LED high after an unlocked cycle");

endmodule

//--- source/debug_scratch_mem.sv
// word scratch memory standing in for the debug module slave memory
// byte addresses below 4*DBG_MEM_WORDS are valid, the two low bits are ignored
// read data and error are registered, valid one cycle after the request
// a write also returns the old word, out of range returns zero with error
// reset clears every word

`timescale 1ns/1ps

module debug_scratch_mem (
  input  logic                      s_soc_clk,
  input  logic                      s_soc_rstn,
  input  logic                      req_i,
  input  soc_domain_pkg::apb_addr_t addr_i,
  input  logic                      we_i,
  input  soc_domain_pkg::apb_data_t wdata_i,
  output soc_domain_pkg::apb_data_t rdata_o,
  output logic                      err_o
);

  localparam int unsigned WORDS = soc_domain_pkg::DBG_MEM_WORDS;
  localparam int unsigned IDX_W = $bits(soc_domain_pkg::dbg_mem_idx_t);
  // first byte address past the memory
  localparam soc_domain_pkg::apb_addr_t ADDR_LIMIT = 4 * WORDS;

  soc_domain_pkg::apb_data_t    mem_q [WORDS];
  soc_domain_pkg::dbg_mem_idx_t idx;
  logic                         in_range;

  // ****************************************
  // address decode
  // ****************************************

  assign in_range = (addr_i < ADDR_LIMIT);
  // word select above the byte offset
  assign idx      = addr_i[2 +: IDX_W];

  // ****************************************
  // storage and read register
  // ****************************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      for (int i = 0; i < WORDS; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
      err_o   <= 1'b0;
    end else if (req_i) begin
      if (in_range) begin
        if (we_i) begin
          mem_q[idx] <= wdata_i;
        end
        // old content, the write lands on the same edge
        rdata_o <= mem_q[idx];
        err_o   <= 1'b0;
      end else begin
        // outside the memory, nothing stored
        rdata_o <= '0;
        err_o   <= 1'b1;
      end
    end
  end

endmodule

//--- source/soc_domain_pkg.sv
// shared constants and types of the SoC domain subset
// widths are fixed at 32 bits, the debug bus carries whole words only
// blink intervals are simulation sized, silicon needs far larger values
// the scratch memory size must be a power of two

package soc_domain_pkg;

  // ****************************************
  // bus widths
  // ****************************************

  localparam int unsigned APB_ADDR_WIDTH = 32;
  localparam int unsigned APB_DATA_WIDTH = 32;

  // byte address and data word on APB and the per bus
  typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

  // ****************************************
  // debug scratch memory
  // ****************************************

  localparam int unsigned DBG_MEM_WORDS = 16;
  // word index, byte address bits above the two low ones
  typedef logic [$clog2(DBG_MEM_WORDS)-1:0] dbg_mem_idx_t;

  // ****************************************
  // reset and clock monitors
  // ****************************************

  // release flops in the peripheral reset synchronizer
  localparam int unsigned RST_SYNC_STAGES = 2;
  // blink half periods in s_soc_clk cycles
  localparam int unsigned REF_BLINK_CYCLES = 8;
  localparam int unsigned ETH_BLINK_CYCLES = 5;

endpackage

//--- source/soc_domain_top.sv
// SoC domain subset: reset combiner, APB debug bridge, lock LEDs
// all logic runs on s_soc_clk, inputs are assumed synchronous to it
// bridge and scratch memory sit in the peripheral reset domain
// the lock monitors only follow the external reset

`timescale 1ns/1ps

module soc_domain_top #(
  parameter int unsigned REF_BLINK_CYCLES = soc_domain_pkg::REF_BLINK_CYCLES,
  parameter int unsigned ETH_BLINK_CYCLES = soc_domain_pkg::ETH_BLINK_CYCLES
) (
  input  logic                      s_soc_clk,
  input  logic                      s_soc_rstn,
  // APB debug slave
  input  soc_domain_pkg::apb_addr_t paddr_i,
  input  soc_domain_pkg::apb_data_t pwdata_i,
  input  logic                      pwrite_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  output soc_domain_pkg::apb_data_t prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // reset sources
  input  logic                      wd_expired_i,
  input  logic                      ndmreset_i,
  // lock levels, already on s_soc_clk
  input  logic                      ref_lock_i,
  input  logic                      eth_lock_i,
  output logic                      periph_rstn_o,
  output logic                      ld_ref_clk_lock_o,
  output logic                      ld_ref_clk_blink_o,
  output logic                      ld_eth_clk_lock_o,
  output logic                      ld_eth_clk_blink_o
);

  logic                      s_periph_rstn;
  // per bus between bridge and memory
  logic                      s_per_req;
  soc_domain_pkg::apb_addr_t s_per_addr;
  logic                      s_per_we;
  soc_domain_pkg::apb_data_t s_per_wdata;
  soc_domain_pkg::apb_data_t s_per_rdata;
  logic                      s_per_err;

  // ****************************************
  // peripheral reset
  // ****************************************

  soc_reset_ctrl u_reset_ctrl (
    .s_soc_clk     (s_soc_clk),
    .s_soc_rstn    (s_soc_rstn),
    .wd_expired_i  (wd_expired_i),
    .ndmreset_i    (ndmreset_i),
    .periph_rstn_o (s_periph_rstn)
  );

  assign periph_rstn_o = s_periph_rstn;

  // ****************************************
  // debug bus
  // ****************************************

  apb_per_bridge u_apb_bridge (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_periph_rstn),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .pwrite_i    (pwrite_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .per_req_o   (s_per_req),
    .per_addr_o  (s_per_addr),
    .per_we_o    (s_per_we),
    .per_wdata_o (s_per_wdata),
    .per_rdata_i (s_per_rdata),
    .per_err_i   (s_per_err)
  );

  debug_scratch_mem u_dbg_mem (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_periph_rstn),
    .req_i      (s_per_req),
    .addr_i     (s_per_addr),
    .we_i       (s_per_we),
    .wdata_i    (s_per_wdata),
    .rdata_o    (s_per_rdata),
    .err_o      (s_per_err)
  );

  // ****************************************
  // clock lock LEDs
  // ****************************************

  clk_lock_monitor #(
    .BLINK_CYCLES (REF_BLINK_CYCLES)
  ) u_ref_clk_mon (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .locked_i   (ref_lock_i),
    .ld_lock_o  (ld_ref_clk_lock_o),
    .ld_blink_o (ld_ref_clk_blink_o)
  );

  clk_lock_monitor #(
    .BLINK_CYCLES (ETH_BLINK_CYCLES)
  ) u_eth_clk_mon (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .locked_i   (eth_lock_i),
    .ld_lock_o  (ld_eth_clk_lock_o),
    .ld_blink_o (ld_eth_clk_blink_o)
  );

endmodule

//--- source/soc_reset_ctrl.sv
// peripheral reset combiner for the SoC domain
// external reset, watchdog expiry and debug ndmreset all assert asynchronously
// release is synchronized to s_soc_clk over RST_SYNC_STAGES flops
// watchdog and ndmreset are active-high levels, glitches on them reset too

`timescale 1ns/1ps

module soc_reset_ctrl (
  input  logic s_soc_clk,
  input  logic s_soc_rstn,
  input  logic wd_expired_i,
  input  logic ndmreset_i,
  output logic periph_rstn_o
);

  localparam int unsigned STAGES = soc_domain_pkg::RST_SYNC_STAGES;

  // ****************************************
  // source combination
  // ****************************************

  // low while any source is active
  logic rst_src_n;
  // release chain, index 0 sees the constant one first
  logic [STAGES-1:0] sync_q;

  assign rst_src_n = s_soc_rstn & ~wd_expired_i & ~ndmreset_i;

  // ****************************************
  // release synchronizer
  // ****************************************

  // assert immediately, deassert after STAGES edges
  always_ff @(posedge s_soc_clk or negedge rst_src_n) begin
    if (!rst_src_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[STAGES-2:0], 1'b1};
    end
  end

  assign periph_rstn_o = sync_q[STAGES-1];

  // ****************************************
  // checks
  // ****************************************

  // any debug or watchdog request must hold the peripherals in reset
  a_src_holds_reset : assert property (@(posedge s_soc_clk)
    (wd_expired_i || ndmreset_i) |-> !periph_rstn_o)
    else $error("periph reset released while a reset source is active");

endmodule
